// File: Makefile
TOP = tb_task_injector
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build folder and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG)
	cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: files.f
+incdir+.
ti_pkg.sv
packet_receiver.sv
inject_ctrl.sv
task_header_builder.sv
packet_sender.sv
task_injector.sv
tb_task_injector.sv

// File: inject_ctrl.sv
`default_nettype none

module inject_ctrl (
    input  wire logic               clk_i,
    input  wire logic               rst_ni,
    input  wire ti_pkg::rx_event_t  rx_event_i,
    input  wire ti_pkg::alloc_msg_t alloc_i,
    input  wire logic               src_rx_i,
    input  wire ti_pkg::flit_t      src_data_i,
    output logic                    src_credit_o,
    output ti_pkg::flit_t           size_word_o,
    output logic [1:0]              size_sel_o,
    output logic                    size_we_o,
    output logic [7:0]              task_idx_o,
    output logic                    send_start_o,
    input  wire logic               send_done_i
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_TEXT,
        ST_DATA,
        ST_BSS,
        ST_ENTRY,
        ST_SEND,
        ST_NEXT,
        ST_WAIT
    } inj_state_e;

    inj_state_e state_q;
    inj_state_e state_d;

    ti_pkg::flit_t tasks_done;  // tasks sent, the current one included.
    logic          last_task;
    logic          alloc_evt;
    logic          done_evt;

    assign alloc_evt  = rx_event_i.valid && rx_event_i.alloc;
    assign done_evt   = rx_event_i.valid && rx_event_i.map_complete;
    assign tasks_done = ti_pkg::flit_t'(task_idx_o) + 1'b1;
    assign last_task  = (tasks_done >= alloc_i.task_cnt);

    // ==========================================================
    // size words from the source
    // ==========================================================

    assign src_credit_o = state_q inside {ST_TEXT, ST_DATA, ST_BSS, ST_ENTRY};
    assign size_we_o    = src_credit_o && src_rx_i;
    assign size_word_o  = src_data_i;

    always_comb begin
        case (state_q)
            ST_TEXT: size_sel_o = 2'd0;
            ST_DATA: size_sel_o = 2'd1;
            ST_BSS:  size_sel_o = 2'd2;
            default: size_sel_o = 2'd3;  // entry point.
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:  if (alloc_evt) state_d = ST_TEXT;
            ST_TEXT:  if (size_we_o) state_d = ST_DATA;
            ST_DATA:  if (size_we_o) state_d = ST_BSS;
            ST_BSS:   if (size_we_o) state_d = ST_ENTRY;
            ST_ENTRY: if (size_we_o) state_d = ST_SEND;
            ST_SEND:  if (send_done_i) state_d = ST_NEXT;
            ST_NEXT:  state_d = last_task ? ST_WAIT : ST_TEXT;
            ST_WAIT:  if (done_evt) state_d = ST_IDLE;
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= ST_IDLE;
            task_idx_o   <= '0;
            send_start_o <= 1'b0;
        end else begin
            state_q      <= state_d;
            send_start_o <= (state_q == ST_ENTRY) && size_we_o;  // header ready next cycle.
            if (state_q == ST_IDLE)
                task_idx_o <= '0;
            else if (state_q == ST_NEXT && !last_task)
                task_idx_o <= task_idx_o + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: packet_receiver.sv
`default_nettype none

`include "ti_config.svh"

module packet_receiver (
    input  wire logic          clk_i,
    input  wire logic          rst_ni,
    input  wire logic          noc_rx_i,
    input  wire ti_pkg::flit_t noc_data_i,
    output logic               noc_credit_o,
    output ti_pkg::rx_event_t  rx_event_o,
    output ti_pkg::alloc_msg_t alloc_o
);

    localparam int HdrSize  = `TI_HEADER_SIZE;
    localparam int MaxPld   = `TI_MAX_PAYLOAD;
    localparam int MaxTasks = `TI_MAX_TASKS;
    localparam int MaxFlits = HdrSize - 2 + MaxPld;  // longest payload size kept.
    localparam int HdrIdxW  = $clog2(HdrSize);
    localparam int PldIdxW  = $clog2(MaxPld);

    typedef enum logic [2:0] {
        RX_HEADER,
        RX_SIZE,
        RX_PACKET,
        RX_DROP,
        RX_DECODE
    } rx_state_e;

    rx_state_e state_q;
    rx_state_e state_d;

    ti_pkg::flit_t [HdrSize-1:0] hdr_q;
    ti_pkg::flit_t [MaxPld-1:0]  pld_q;
    ti_pkg::flit_t               pkt_size_q;
    ti_pkg::flit_t               rcv_cnt_q;   // flits taken after the size flit.
    ti_pkg::alloc_msg_t          alloc_q;

    logic               take;
    logic               last_flit;
    logic               is_delivery;
    logic [HdrIdxW-1:0] hdr_idx;
    logic [PldIdxW-1:0] pld_idx;

    assign noc_credit_o = (state_q != RX_DECODE);  // closed only while decoding.
    assign take         = noc_rx_i && noc_credit_o;
    assign last_flit    = (rcv_cnt_q == pkt_size_q - 1'b1);
    assign hdr_idx      = HdrIdxW'(rcv_cnt_q + 2);
    assign pld_idx      = PldIdxW'(rcv_cnt_q - (HdrSize - 2));

    always_comb begin
        state_d = state_q;
        case (state_q)
            RX_HEADER: if (take) state_d = RX_SIZE;
            RX_SIZE: begin
                if (take) begin
                    if (noc_data_i == '0)
                        state_d = RX_HEADER;
                    else if (noc_data_i > ti_pkg::flit_t'(MaxFlits))
                        state_d = RX_DROP;
                    else
                        state_d = RX_PACKET;
                end
            end
            RX_PACKET: if (take && last_flit) state_d = RX_DECODE;
            RX_DROP:   if (take && last_flit) state_d = RX_HEADER;
            default:   state_d = RX_HEADER;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= RX_HEADER;
            pkt_size_q <= '0;
            rcv_cnt_q  <= '0;
        end else begin
            state_q <= state_d;
            if (take && state_q == RX_SIZE) begin
                pkt_size_q <= noc_data_i;
                rcv_cnt_q  <= '0;
            end else if (take && (state_q inside {RX_PACKET, RX_DROP})) begin
                rcv_cnt_q <= rcv_cnt_q + 1'b1;
            end
        end
    end

    // header flits first, the rest goes to the payload store.
    always_ff @(posedge clk_i) begin
        if (take) begin
            case (state_q)
                RX_HEADER: hdr_q[0] <= noc_data_i;
                RX_SIZE:   hdr_q[1] <= noc_data_i;
                RX_PACKET: begin
                    if (rcv_cnt_q < HdrSize - 2)
                        hdr_q[hdr_idx] <= noc_data_i;
                    else
                        pld_q[pld_idx] <= noc_data_i;
                end
                default: ;
            endcase
        end
    end

    // ==========================================================
    // decode
    // ==========================================================

    assign is_delivery = (state_q == RX_DECODE) && (hdr_q[2] == ti_pkg::MESSAGE_DELIVERY);

    always_comb begin
        rx_event_o.alloc        = is_delivery && (pld_q[0] == ti_pkg::APP_ALLOCATION_REQUEST);
        rx_event_o.map_complete = is_delivery && (pld_q[0] == ti_pkg::APP_MAPPING_COMPLETE);
        rx_event_o.valid        = rx_event_o.alloc || rx_event_o.map_complete;
    end

    always_ff @(posedge clk_i) begin
        if (rx_event_o.alloc) begin
            alloc_q.app_id   <= pld_q[1];
            alloc_q.task_cnt <= pld_q[2];
            for (int i = 0; i < MaxTasks; i++) begin
                alloc_q.target[i] <= pld_q[3 + i];
            end
        end
    end

    assign alloc_o = alloc_q;

endmodule

`default_nettype wire

// File: packet_sender.sv
`default_nettype none

`include "ti_config.svh"

module packet_sender (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,
    input  wire ti_pkg::task_hdr_t hdr_i,
    input  wire logic              send_start_i,
    output logic                   send_done_o,
    output logic                   noc_tx_o,
    input  wire logic              noc_credit_i,
    output ti_pkg::flit_t          noc_data_o,
    input  wire logic              src_rx_i,
    input  wire ti_pkg::flit_t     src_data_i,
    output logic                   src_credit_o
);

    localparam int HdrSize = `TI_HEADER_SIZE;
    localparam int IdxW    = $clog2(HdrSize + 1);

    logic            busy_q;
    logic [IdxW-1:0] hdr_idx_q;
    ti_pkg::flit_t   sent_cnt_q;  // flits sent so far, target and size included.
    ti_pkg::flit_t   hdr_flit;
    logic            in_header;
    logic            fire;
    logic            last;

    assign in_header    = (hdr_idx_q != IdxW'(HdrSize));
    assign noc_tx_o     = busy_q && (in_header || src_rx_i);
    assign src_credit_o = busy_q && !in_header && noc_credit_i;  // credit chained back.
    assign noc_data_o   = in_header ? hdr_flit : src_data_i;
    assign fire         = noc_tx_o && noc_credit_i;
    assign last         = (sent_cnt_q == hdr_i.payload_size + 1'b1);

    always_comb begin
        case (hdr_idx_q)
            0:       hdr_flit = hdr_i.target;
            1:       hdr_flit = hdr_i.payload_size;
            2:       hdr_flit = ti_pkg::flit_t'(hdr_i.service);
            3:       hdr_flit = hdr_i.task_id;
            4:       hdr_flit = hdr_i.mapper_addr;
            8:       hdr_flit = hdr_i.mapper_id;
            9:       hdr_flit = hdr_i.data_size;
            10:      hdr_flit = hdr_i.text_size;
            11:      hdr_flit = hdr_i.bss_size;
            12:      hdr_flit = hdr_i.entry_point;
            default: hdr_flit = '0;  // flits 5 to 7.
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q      <= 1'b0;
            hdr_idx_q   <= '0;
            sent_cnt_q  <= '0;
            send_done_o <= 1'b0;
        end else begin
            send_done_o <= fire && last;
            if (send_start_i) begin
                busy_q     <= 1'b1;
                hdr_idx_q  <= '0;
                sent_cnt_q <= '0;
            end else if (fire) begin
                sent_cnt_q <= sent_cnt_q + 1'b1;
                if (in_header)
                    hdr_idx_q <= hdr_idx_q + 1'b1;
                if (last)
                    busy_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: task_header_builder.sv
`default_nettype none

`include "ti_config.svh"

module task_header_builder (
    input  wire logic               clk_i,
    input  wire logic               rst_ni,
    input  wire ti_pkg::flit_t      size_word_i,
    input  wire logic [1:0]         size_sel_i,
    input  wire logic               size_we_i,
    input  wire logic [7:0]         task_idx_i,
    input  wire ti_pkg::alloc_msg_t alloc_i,
    input  wire ti_pkg::flit_t      mapper_address_i,
    output ti_pkg::task_hdr_t       hdr_o
);

    localparam int HdrSize = `TI_HEADER_SIZE;
    localparam int TblIdxW = $clog2(`TI_MAX_TASKS);

    ti_pkg::task_hdr_t hdr_q;
    ti_pkg::flit_t     target;
    ti_pkg::flit_t     task_id;
    ti_pkg::flit_t     code_words;

    assign target     = alloc_i.target[task_idx_i[TblIdxW-1:0]];
    assign task_id    = ti_pkg::flit_t'({alloc_i.app_id[7:0], task_idx_i});
    assign code_words = hdr_q.payload_size >> 2;  // text plus data in words.

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hdr_q <= '0;
        end else if (size_we_i) begin
            case (size_sel_i)
                2'd0: begin
                    hdr_q.target       <= target;
                    hdr_q.payload_size <= size_word_i;  // running sum starts here.
                    hdr_q.service      <= ti_pkg::TASK_ALLOCATION;
                    hdr_q.task_id      <= task_id;
                    hdr_q.mapper_addr  <= mapper_address_i;
                    hdr_q.mapper_id    <= '0;
                    hdr_q.text_size    <= size_word_i;
                end
                2'd1: begin
                    hdr_q.data_size    <= size_word_i;
                    hdr_q.payload_size <= hdr_q.payload_size + size_word_i;
                end
                2'd2: begin
                    hdr_q.bss_size <= size_word_i;
                end
                default: begin
                    // final size counts header flits after the size flit.
                    hdr_q.entry_point  <= size_word_i;
                    hdr_q.payload_size <= code_words + ti_pkg::flit_t'(HdrSize - 2);
                end
            endcase
        end
    end

    assign hdr_o = hdr_q;

endmodule

`default_nettype wire

// File: task_injector.sv
`default_nettype none

module task_injector (
    input  wire logic          clk_i,
    input  wire logic          rst_ni,

    input  wire logic          src_rx_i,
    input  wire ti_pkg::flit_t src_data_i,
    output logic               src_credit_o,
    input  wire ti_pkg::flit_t mapper_address_i,

    // noc output.
    output logic               noc_tx_o,
    input  wire logic          noc_credit_i,
    output ti_pkg::flit_t      noc_data_o,

    // noc input.
    input  wire logic          noc_rx_i,
    output logic               noc_credit_o,
    input  wire ti_pkg::flit_t noc_data_i
);

    ti_pkg::rx_event_t  rx_event;
    ti_pkg::alloc_msg_t alloc;
    ti_pkg::task_hdr_t  hdr;
    ti_pkg::flit_t      size_word;
    logic [1:0]         size_sel;
    logic               size_we;
    logic [7:0]         task_idx;
    logic               send_start;
    logic               send_done;
    logic               ctrl_credit;
    logic               send_credit;

    // controller and sender never open the source together.
    assign src_credit_o = ctrl_credit | send_credit;

    packet_receiver u_receiver (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .noc_rx_i     (noc_rx_i),
        .noc_data_i   (noc_data_i),
        .noc_credit_o (noc_credit_o),
        .rx_event_o   (rx_event),
        .alloc_o      (alloc)
    );

    inject_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .rx_event_i   (rx_event),
        .alloc_i      (alloc),
        .src_rx_i     (src_rx_i),
        .src_data_i   (src_data_i),
        .src_credit_o (ctrl_credit),
        .size_word_o  (size_word),
        .size_sel_o   (size_sel),
        .size_we_o    (size_we),
        .task_idx_o   (task_idx),
        .send_start_o (send_start),
        .send_done_i  (send_done)
    );

    task_header_builder u_builder (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .size_word_i      (size_word),
        .size_sel_i       (size_sel),
        .size_we_i        (size_we),
        .task_idx_i       (task_idx),
        .alloc_i          (alloc),
        .mapper_address_i (mapper_address_i),
        .hdr_o            (hdr)
    );

    packet_sender u_sender (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .hdr_i        (hdr),
        .send_start_i (send_start),
        .send_done_o  (send_done),
        .noc_tx_o     (noc_tx_o),
        .noc_credit_i (noc_credit_i),
        .noc_data_o   (noc_data_o),
        .src_rx_i     (src_rx_i),
        .src_data_i   (src_data_i),
        .src_credit_o (send_credit)
    );

endmodule

`default_nettype wire

// File: tb_task_injector.sv
`default_nettype none

`include "ti_config.svh"

module tb_task_injector;

    localparam int            HdrSize    = `TI_HEADER_SIZE;
    localparam int            NumPkts    = 5;
    localparam ti_pkg::flit_t MapperAddr = 32'h0000_0203;

    logic          clk_i        = 1'b0;
    logic          rst_ni       = 1'b0;
    logic          src_rx_i     = 1'b0;
    ti_pkg::flit_t src_data_i   = '0;
    logic          src_credit_o;
    ti_pkg::flit_t mapper_address_i;
    logic          noc_tx_o;
    logic          noc_credit_i = 1'b1;
    ti_pkg::flit_t noc_data_o;
    logic          noc_rx_i     = 1'b0;
    logic          noc_credit_o;
    ti_pkg::flit_t noc_data_i   = '0;

    ti_pkg::flit_t exp_q [$];    // expected noc output flits, all packets in a row.
    ti_pkg::flit_t src_q [$];    // words the source offers, in order.
    ti_pkg::flit_t msg_pld [$];  // payload of the next incoming message.
    ti_pkg::flit_t tgt_tbl [`TI_MAX_TASKS];
    int            text_sz [NumPkts] = '{'h40, 'h10, 'h30, 'h08, 'h20};
    int            data_sz [NumPkts] = '{'h20, 'h10, 'h00, 'h04, 'h20};
    int            src_rd     = 0;
    int            out_pos    = 0;
    int            out_len    = 0;
    int            out_pkts   = 0;
    int            checks     = 0;
    int            errors     = 0;
    logic          stall_en   = 1'b0;
    logic          stalled    = 1'b0;
    ti_pkg::flit_t stall_data = '0;
    ti_pkg::flit_t exp_flit;

    assign mapper_address_i = MapperAddr;

    always #4 clk_i = ~clk_i;

    task_injector u_dut (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .src_rx_i         (src_rx_i),
        .src_data_i       (src_data_i),
        .src_credit_o     (src_credit_o),
        .mapper_address_i (mapper_address_i),
        .noc_tx_o         (noc_tx_o),
        .noc_credit_i     (noc_credit_i),
        .noc_data_o       (noc_data_o),
        .noc_rx_i         (noc_rx_i),
        .noc_credit_o     (noc_credit_o),
        .noc_data_i       (noc_data_i)
    );

    // ==========================================================
    // expected packets and incoming messages
    // ==========================================================

    function automatic int packet_len(input int text, input int data);
        return HdrSize + (text + data) / 4;
    endfunction

    task automatic fill_table();
        foreach (tgt_tbl[i])
            tgt_tbl[i] = $urandom & 32'h0000_ffff;
    endtask

    // header of one task, then its code words. the source gets the same words.
    task automatic queue_task(input ti_pkg::flit_t app_id, input int idx, input int pkt);
        ti_pkg::flit_t text;
        ti_pkg::flit_t data;
        ti_pkg::flit_t bss;
        ti_pkg::flit_t entry;
        ti_pkg::flit_t word;
        text  = ti_pkg::flit_t'(text_sz[pkt]);
        data  = ti_pkg::flit_t'(data_sz[pkt]);
        bss   = $urandom & 32'h0000_0ffc;
        entry = $urandom;
        exp_q.push_back(tgt_tbl[idx]);
        exp_q.push_back(ti_pkg::flit_t'(HdrSize - 2) + (text + data) / 4);
        exp_q.push_back(ti_pkg::TASK_ALLOCATION);
        exp_q.push_back({16'h0000, app_id[7:0], idx[7:0]});
        exp_q.push_back(MapperAddr);
        repeat (4)
            exp_q.push_back(ti_pkg::flit_t'(0));  // flits 5 to 8.
        exp_q.push_back(data);
        exp_q.push_back(text);
        exp_q.push_back(bss);
        exp_q.push_back(entry);
        src_q.push_back(text);
        src_q.push_back(data);
        src_q.push_back(bss);
        src_q.push_back(entry);
        repeat ((text + data) / 4) begin
            word = $urandom;
            src_q.push_back(word);
            exp_q.push_back(word);
        end
    endtask

    // called on a rising edge and returns one edge after the last flit.
    task automatic send_message(input ti_pkg::flit_t service);
        ti_pkg::flit_t msg [$];
        logic          dropped;
        dropped = (msg_pld.size() > `TI_MAX_PAYLOAD);  // too long for the store.
        msg.push_back(32'h0000_0000);
        msg.push_back(ti_pkg::flit_t'(HdrSize - 2 + msg_pld.size()));
        msg.push_back(service);
        for (int i = 3; i < HdrSize; i++)
            msg.push_back($urandom);
        foreach (msg_pld[i])
            msg.push_back(msg_pld[i]);
        foreach (msg[i]) begin
            noc_rx_i   <= 1'b1;
            noc_data_i <= msg[i];
            @(posedge clk_i);
            while (!noc_credit_o)
                @(posedge clk_i);
        end
        noc_rx_i <= 1'b0;
        @(posedge clk_i);
        // credit closes for one decode cycle unless the packet was dropped.
        assert (noc_credit_o == dropped) else begin
            errors++;
            $display("FAIL noc_credit_o: got %h expected %h after the last flit",
                     noc_credit_o, dropped);
        end
    endtask

    task automatic send_alloc(input ti_pkg::flit_t app_id, input int count);
        msg_pld.delete();
        msg_pld.push_back(ti_pkg::APP_ALLOCATION_REQUEST);
        msg_pld.push_back(app_id);
        msg_pld.push_back(ti_pkg::flit_t'(count));
        foreach (tgt_tbl[i])
            msg_pld.push_back(tgt_tbl[i]);
        send_message(ti_pkg::MESSAGE_DELIVERY);
    endtask

    task automatic send_map_complete();
        msg_pld.delete();
        msg_pld.push_back(ti_pkg::APP_MAPPING_COMPLETE);
        send_message(ti_pkg::MESSAGE_DELIVERY);
    endtask

    // an over-long allocation and an allocation under a foreign service.
    task automatic send_ignored_messages();
        msg_pld.delete();
        msg_pld.push_back(ti_pkg::APP_ALLOCATION_REQUEST);
        msg_pld.push_back(32'h0000_0009);
        msg_pld.push_back(32'h0000_0001);
        while (msg_pld.size() <= `TI_MAX_PAYLOAD)
            msg_pld.push_back($urandom);
        send_message(ti_pkg::MESSAGE_DELIVERY);
        msg_pld.delete();
        msg_pld.push_back(ti_pkg::APP_ALLOCATION_REQUEST);
        msg_pld.push_back(32'h0000_0009);
        msg_pld.push_back(32'h0000_0001);
        foreach (tgt_tbl[i])
            msg_pld.push_back(tgt_tbl[i]);
        send_message(ti_pkg::TASK_TERMINATED);
    endtask

    task automatic wait_drained();
        @(posedge clk_i);
        while (exp_q.size() != 0)
            @(posedge clk_i);
    endtask

    // ==========================================================
    // source, noc credit and output monitor
    // ==========================================================

    always @(posedge clk_i) begin
        if (src_rx_i && src_credit_o)
            src_rd = src_rd + 1;
        if (!src_rx_i || src_credit_o) begin  // an offered word stays until taken.
            if (src_rd < src_q.size() && $urandom_range(3) != 0) begin
                src_rx_i   <= 1'b1;
                src_data_i <= src_q[src_rd];
            end else begin
                src_rx_i <= 1'b0;
            end
        end
    end

    always @(posedge clk_i) begin
        if (stall_en)
            noc_credit_i <= ($urandom_range(99) >= 40);
        else
            noc_credit_i <= 1'b1;
    end

    always @(posedge clk_i) begin
        if (rst_ni && noc_tx_o && noc_credit_i) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected flit %h on the NoC output while no packet was due",
                         noc_data_o);
            end else begin
                exp_flit = exp_q.pop_front();
                checks++;
                assert (noc_data_o == exp_flit) else begin
                    errors++;
                    $display("FAIL noc_data_o: packet %0d flit %0d got %h expected %h",
                             out_pkts, out_pos, noc_data_o, exp_flit);
                end
            end
            if (out_pos == 1)
                out_len = int'(noc_data_o);
            if (out_pos > 1 && out_pos == out_len + 1) begin
                out_pos = 0;
                out_pkts++;
            end else begin
                out_pos++;
            end
        end
    end

    // a stalled flit must still be offered, unchanged.
    always @(posedge clk_i) begin
        if (rst_ni && stalled) begin
            assert (noc_tx_o) else begin
                errors++;
                $display("FAIL noc_tx_o: got %h expected %h after a stall", noc_tx_o, 1'b1);
            end
            assert (noc_data_o == stall_data) else begin
                errors++;
                $display("FAIL noc_data_o: got %h expected %h after a stall",
                         noc_data_o, stall_data);
            end
        end
        stalled    = noc_tx_o && !noc_credit_i;
        stall_data = noc_data_o;
    end

    src_credit_gated: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (noc_tx_o && !noc_credit_i) |-> !src_credit_o)
    else begin
        errors++;
        $display("FAIL src_credit_o: got %h expected %h during back-pressure", 1'b1, 1'b0);
    end

    initial begin : watchdog
        int limit;
        limit = 2000;
        for (int i = 0; i < NumPkts; i++)
            limit += packet_len(text_sz[i], data_sz[i]) * 20;
        repeat (limit) @(posedge clk_i);
        $display("timeout after %0d cycles with %0d flits still expected", limit, exp_q.size());
        $display("Done: errors found");
        $finish;
    end

    // ==========================================================
    // test sequence
    // ==========================================================

    initial begin
        void'($urandom(32'h449e));
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        repeat (2) @(posedge clk_i);

        send_map_complete();  // nothing allocated yet.
        repeat (20) @(posedge clk_i);

        fill_table();
        queue_task(32'h0000_0011, 0, 0);
        send_alloc(32'h0000_0011, 1);
        wait_drained();
        send_map_complete();

        // three tasks with random back-pressure.
        stall_en <= 1'b1;
        fill_table();
        for (int i = 0; i < 3; i++)
            queue_task(32'h0000_0022, i, i + 1);
        send_alloc(32'h0000_0022, 3);
        wait_drained();
        send_map_complete();
        stall_en <= 1'b0;

        send_ignored_messages();
        repeat (20) @(posedge clk_i);
        fill_table();
        queue_task(32'h0000_0033, 0, 4);
        send_alloc(32'h0000_0033, 1);
        wait_drained();
        send_map_complete();
        repeat (20) @(posedge clk_i);

        assert (src_rd == src_q.size()) else begin
            errors++;
            $display("FAIL source word count: got %h expected %h", src_rd, src_q.size());
        end
        assert (out_pkts == NumPkts) else begin
            errors++;
            $display("FAIL noc packet count: got %h expected %h", out_pkts, NumPkts);
        end
        $display("flits checked %0d, packets %0d, errors %0d", checks, out_pkts, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: ti_config.svh
`ifndef TI_CONFIG_SVH
`define TI_CONFIG_SVH

// ==========================================================
// task injector configuration
// ==========================================================

// width of a noc flit and of a source word.
`define TI_FLIT_W 32

// header flits of every message, target and size included.
`define TI_HEADER_SIZE 13

// receive payload store depth in words.
`define TI_MAX_PAYLOAD 16

// entries in the allocation target table.
`define TI_MAX_TASKS 8

`endif

// File: ti_pkg.sv
`default_nettype none

`include "ti_config.svh"

package ti_pkg;

    typedef logic [`TI_FLIT_W-1:0] flit_t;

    // ==========================================================
    // service and delivery codes
    // ==========================================================

    typedef enum logic [`TI_FLIT_W-1:0] {
        MESSAGE_REQUEST  = 'h0000_0010,
        MESSAGE_DELIVERY = 'h0000_0020,
        DATA_AV          = 'h0000_0031,
        TASK_ALLOCATION  = 'h0000_0040,
        TASK_TERMINATED  = 'h0000_0070,
        TASK_MIGRATION   = 'h0000_0080
    } service_e;

    // first payload word of a delivery.
    typedef enum logic [`TI_FLIT_W-1:0] {
        APP_ALLOCATION_REQUEST = 'h0000_0240,
        APP_MAPPING_COMPLETE   = 'h0000_0241
    } delivery_e;

    // ==========================================================
    // message structs
    // ==========================================================

    typedef struct packed {
        flit_t    target;       // flit 0.
        flit_t    payload_size;
        service_e service;
        flit_t    task_id;
        flit_t    mapper_addr;  // flit 4.
        flit_t    mapper_id;    // flit 8.
        flit_t    data_size;
        flit_t    text_size;
        flit_t    bss_size;
        flit_t    entry_point;  // flit 12.
    } task_hdr_t;

    typedef struct packed {
        flit_t                     app_id;
        flit_t                     task_cnt;
        flit_t [`TI_MAX_TASKS-1:0] target;
    } alloc_msg_t;

    typedef struct packed {
        logic valid;
        logic alloc;
        logic map_complete;
    } rx_event_t;

endpackage

`default_nettype wire
